// ==== hdl/mdu_defs.svh ====
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// ******************************
// Datapath sizing
// ******************************

// Width of HI, LO and both operands
`define DATA_WIDTH 32

// Start edge to finish for any multiply.
// The divider is fixed at DATA_WIDTH + 1
`define MUL_CYCLES 4

`endif

// ==== hdl/mduOpPkg.sv ====
package mduOpPkg;

    // ******************************
    // Multiply/divide operations
    // ******************************

    typedef enum logic [3:0] {
        OpMult  = 4'h0,
        OpMultu = 4'h1,
        OpDiv   = 4'h2,
        OpDivu  = 4'h3,
        OpMadd  = 4'h4,
        OpMaddu = 4'h5,
        OpMsub  = 4'h6,
        OpMsubu = 4'h7
    } mduOpE;

    // How a finished result is merged into HI/LO
    typedef enum logic [1:0] {
        AccNone = 2'b00,
        AccAdd  = 2'b01,
        AccSub  = 2'b10
    } accOpE;

endpackage

// ==== hdl/hiLoPkg.sv ====
`include "mdu_defs.svh"

package hiLoPkg;
    import mduOpPkg::*;

    // Full 64-bit HI/LO value, hi in the upper half
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] hi;
        logic [`DATA_WIDTH-1:0] lo;
    } hiLoPairT;

    // Producer output, raw value plus merge mode
    typedef struct packed {
        hiLoPairT value;
        accOpE    acc;
    } mduResultT;

    // Start request
    typedef struct packed {
        mduOpE                  op;
        logic [`DATA_WIDTH-1:0] srcA;
        logic [`DATA_WIDTH-1:0] srcB;
    } mduReqT;

endpackage

// ==== hdl/mulDivUnit.sv ====
`timescale 1ns/10ps
`include "mdu_defs.svh"

module mulDivUnit
    import mduOpPkg::*;
    import hiLoPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  mduReqT    req,
    output logic      busy,
    output logic      finish,
    output mduResultT result
);
    localparam int Width = `DATA_WIDTH;
    localparam int CntW  = $clog2(Width + 2);

    mduOpE              opReg;
    logic [Width-1:0]   magA;
    logic [Width-1:0]   magB;
    logic               negOut;
    logic               negRem;
    logic [Width-1:0]   rem;
    logic [Width-1:0]   quo;
    logic [CntW-1:0]    cnt;

    logic               accept;
    logic               aNeg;
    logic               bNeg;
    logic [Width:0]     shifted;
    logic [Width:0]     trial;
    logic [2*Width-1:0] prod;
    logic [2*Width-1:0] prodFix;
    logic [Width-1:0]   quoFix;
    logic [Width-1:0]   remFix;

    function automatic logic isSignedOp(mduOpE op);
        return op inside {OpMult, OpDiv, OpMadd, OpMsub};
    endfunction

    function automatic logic isDivOp(mduOpE op);
        return op inside {OpDiv, OpDivu};
    endfunction

    function automatic accOpE accFor(mduOpE op);
        accOpE code;
        case (op)
            OpMadd, OpMaddu: code = AccAdd;
            OpMsub, OpMsubu: code = AccSub;
            default:         code = AccNone;
        endcase
        return code;
    endfunction

    // Requests while busy are dropped
    assign accept = start && !busy;

    assign aNeg = isSignedOp(req.op) && req.srcA[Width-1];
    assign bNeg = isSignedOp(req.op) && req.srcB[Width-1];

    // ******************************
    // Restoring divide step
    // ******************************
    assign shifted = {rem, quo[Width-1]};
    assign trial   = shifted - {1'b0, magB};

    // Unsigned product of the magnitudes
    assign prod    = {{Width{1'b0}}, magA} * {{Width{1'b0}}, magB};

    // Sign fix-up at the end
    assign prodFix = negOut ? -prod : prod;
    assign quoFix  = negOut ? -quo : quo;
    assign remFix  = negRem ? -rem : rem;

    // ******************************
    // Control
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy   <= 1'b0;
            finish <= 1'b0;
            cnt    <= '0;
        end else if (finish) begin
            busy   <= 1'b0;
            finish <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            // Last counted cycle raises finish
            if (cnt == CntW'(1)) begin
                finish <= 1'b1;
            end
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= isDivOp(req.op) ? CntW'(Width + 1) : CntW'(`MUL_CYCLES);
        end
    end

    // ******************************
    // Datapath
    // ******************************
    always_ff @(posedge clk) begin
        if (accept) begin
            opReg  <= req.op;
            magA   <= aNeg ? -req.srcA : req.srcA;
            magB   <= bNeg ? -req.srcB : req.srcB;
            quo    <= aNeg ? -req.srcA : req.srcA;
            rem    <= '0;
            negOut <= aNeg ^ bNeg;
            negRem <= aNeg;
        end else if (busy && !finish) begin
            // One quotient bit per cycle, the final cycle only fixes signs
            if (isDivOp(opReg) && cnt > CntW'(1)) begin
                if (!trial[Width]) begin
                    rem <= trial[Width-1:0];
                    quo <= {quo[Width-2:0], 1'b1};
                end else begin
                    rem <= shifted[Width-1:0];
                    quo <= {quo[Width-2:0], 1'b0};
                end
            end
            if (cnt == CntW'(1)) begin
                if (isDivOp(opReg)) begin
                    result.value.hi <= remFix;
                    result.value.lo <= quoFix;
                end else begin
                    result.value <= prodFix;
                end
                result.acc <= accFor(opReg);
            end
        end
    end

endmodule

// ==== hdl/hiLoRegs.sv ====
`timescale 1ns/10ps
`include "mdu_defs.svh"

module hiLoRegs
    import mduOpPkg::*;
    import hiLoPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   finish,
    input  mduResultT              result,
    input  logic                   hiWr,
    input  logic                   loWr,
    input  logic [`DATA_WIDTH-1:0] wrData,
    output hiLoPairT               curPair
);
    localparam int Width = `DATA_WIDTH;

    hiLoPairT           pair;
    logic [2*Width-1:0] accSum;
    logic [2*Width-1:0] accDiff;

    // ******************************
    // Accumulate arithmetic
    // ******************************

    // Carries between LO and HI come for free in 64 bits
    assign accSum  = {pair.hi, pair.lo} + {result.value.hi, result.value.lo};
    assign accDiff = {pair.hi, pair.lo} - {result.value.hi, result.value.lo};

    // Next pair, also the bypass to the read port
    always_comb begin
        curPair = pair;
        if (finish) begin
            case (result.acc)
                AccAdd:  {curPair.hi, curPair.lo} = accSum;
                AccSub:  {curPair.hi, curPair.lo} = accDiff;
                default: curPair = result.value;
            endcase
        end else begin
            // MTHI and MTLO
            if (hiWr) begin
                curPair.hi = wrData;
            end
            if (loWr) begin
                curPair.lo = wrData;
            end
        end
    end

    // ******************************
    // Register pair
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pair <= '0;
        end else begin
            pair <= curPair;
        end
    end

endmodule

// ==== hdl/moveFromHiLo.sv ====
`timescale 1ns/10ps
`include "mdu_defs.svh"

module moveFromHiLo
    import hiLoPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdReq,
    input  logic                   rdHi,
    input  logic                   busy,
    input  hiLoPairT               curPair,
    output logic                   rdStall,
    output logic                   rdValid,
    output logic [`DATA_WIDTH-1:0] rdData
);
    logic serve;

    // Hold the request off while a result is pending
    assign rdStall = rdReq && busy;
    assign serve   = rdReq && !busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= serve;
        end
    end

    // Selected half of the bypassed pair
    always_ff @(posedge clk) begin
        if (serve) begin
            rdData <= rdHi ? curPair.hi : curPair.lo;
        end
    end

endmodule

// ==== hdl/mduTop.sv ====
`timescale 1ns/10ps
`include "mdu_defs.svh"

module mduTop
    import hiLoPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  mduReqT                 req,
    input  logic                   hiWr,
    input  logic                   loWr,
    input  logic [`DATA_WIDTH-1:0] wrData,
    input  logic                   rdReq,
    input  logic                   rdHi,
    output logic                   busy,
    output logic                   rdStall,
    output logic                   rdValid,
    output logic [`DATA_WIDTH-1:0] rdData
);
    logic      finish;
    mduResultT result;
    hiLoPairT  curPair;

    // ******************************
    // Producer
    // ******************************
    mulDivUnit uMulDiv (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .finish (finish),
        .result (result)
    );

    // HI/LO buffer with bypass
    hiLoRegs uHiLo (
        .clk     (clk),
        .rst     (rst),
        .finish  (finish),
        .result  (result),
        .hiWr    (hiWr),
        .loWr    (loWr),
        .wrData  (wrData),
        .curPair (curPair)
    );

    // MFHI/MFLO consumer
    moveFromHiLo uMoveFrom (
        .clk     (clk),
        .rst     (rst),
        .rdReq   (rdReq),
        .rdHi    (rdHi),
        .busy    (busy),
        .curPair (curPair),
        .rdStall (rdStall),
        .rdValid (rdValid),
        .rdData  (rdData)
    );

endmodule

// ==== test/mduTop_chk.sv ====
`timescale 1ns/10ps

module mduTopChk (
    input logic clk,
    input logic rst,
    input logic finish,
    input logic busy,
    input logic rdStall,
    input logic rdValid
);
    int assertFails = 0;

    // Finish is a one-cycle strobe
    finishPulse: assert property (@(posedge clk) disable iff (!rst) finish |=> !finish)
        else begin
            assertFails++;
            $error("finish high for two cycles in a row");
        end

    stallOnlyWhenBusy: assert property (@(posedge clk) disable iff (!rst) rdStall |-> busy)
        else begin
            assertFails++;
            $error("rdStall high while the unit is idle");
        end

    // Nothing is served out of a stalled cycle
    noValidAfterStall: assert property (@(posedge clk) disable iff (!rst)
        rdStall |=> !rdValid)
        else begin
            assertFails++;
            $error("rdValid high right after a stalled cycle");
        end

    idleAfterReset: assert property (@(posedge clk) $rose(rst) |-> !busy && !rdValid)
        else begin
            assertFails++;
            $error("busy or rdValid high just after reset release");
        end

endmodule

// ==== test/mduTb.sv ====
`timescale 1ns/10ps
`include "mdu_defs.svh"

module mduTb
    import mduOpPkg::*;
    import hiLoPkg::*;
();
    localparam int Width   = `DATA_WIDTH;
    localparam int MaxWait = 100;

    logic               clk, rst, start, hiWr, loWr, rdReq, rdHi;
    logic               busy, rdStall, rdValid;
    logic [Width-1:0]   wrData, rdData;
    mduReqT             req;
    // Reference HI/LO, hi in the upper half
    logic [2*Width-1:0] model;
    logic [1:0]         pick;
    mduOpE              accOps [4] = '{OpMadd, OpMaddu, OpMsub, OpMsubu};
    integer             seed = 32'h62df2fa6;
    int                 errors = 0;
    int                 checks = 0;

    mduTop uut (.*);

    bind mduTop mduTopChk chk (.clk(clk), .rst(rst), .finish(finish), .busy(busy),
        .rdStall(rdStall), .rdValid(rdValid));

    always #20 clk = ~clk;

    // Raw 64-bit result, remainder in HI and quotient in LO for divides
    function automatic logic [2*Width-1:0] opResult(mduOpE op, logic [Width-1:0] x,
                                                    logic [Width-1:0] y);
        logic signed [2*Width-1:0] sx, sy;
        logic [2*Width-1:0]        ux, uy, q, r;
        sx = {{Width{x[Width-1]}}, x};
        sy = {{Width{y[Width-1]}}, y};
        ux = {{Width{1'b0}}, x};
        uy = {{Width{1'b0}}, y};
        case (op)
            OpMult, OpMadd, OpMsub:    return sx * sy;
            OpMultu, OpMaddu, OpMsubu: return ux * uy;
            OpDiv: begin
                // Zero divisor: all ones, negated (so 1) for a negative dividend
                if (y == 0) begin
                    q = x[Width-1] ? 64'd1 : 64'hFFFF_FFFF;
                    r = sx;
                end else begin
                    q = sx / sy;
                    r = sx % sy;
                end
            end
            default: begin
                if (y == 0) begin
                    q = 64'hFFFF_FFFF;
                    r = ux;
                end else begin
                    q = ux / uy;
                    r = ux % uy;
                end
            end
        endcase
        return {r[Width-1:0], q[Width-1:0]};
    endfunction

    task automatic issueOp(input mduOpE code, input logic [Width-1:0] x,
                           input logic [Width-1:0] y);
        start <= 1'b1;
        req   <= '{op: code, srcA: x, srcB: y};
        @(posedge clk);
        start <= 1'b0;
        case (code)
            OpMadd, OpMaddu: model = model + opResult(code, x, y);
            OpMsub, OpMsubu: model = model - opResult(code, x, y);
            default:         model = opResult(code, x, y);
        endcase
    endtask

    task automatic waitIdle(input int cycles);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (busy && n < MaxWait);
        if (busy) begin
            $display("Timeout: the unit stayed busy for %0d cycles", MaxWait);
            errors++;
        end else if (n != cycles + 2) begin
            // Busy spans start to finish plus the finish cycle itself
            $display("** Error busy cycles expected %h actual %h", cycles + 1, n - 1);
            errors++;
        end
    endtask

    // Read request held through any stall, then the served half is compared
    task automatic readHiLo(input logic hi, input int minStalls);
        logic [Width-1:0] expected;
        int               n;
        expected = hi ? model[2*Width-1:Width] : model[Width-1:0];
        rdReq <= 1'b1;
        rdHi  <= hi;
        n = 0;
        @(posedge clk);
        hiWr <= 1'b0;
        loWr <= 1'b0;
        while (busy && n < MaxWait) begin
            if (!rdStall) begin
                $display("** Error rdStall expected %h actual %h", 1'b1, rdStall);
                errors++;
            end
            if (rdValid) begin
                $display("** Error rdValid expected %h actual %h", 1'b0, rdValid);
                errors++;
            end
            @(posedge clk);
            n++;
        end
        rdReq <= 1'b0;
        if (busy) begin
            $display("Timeout: the read stayed stalled for %0d cycles", MaxWait);
            errors++;
        end else if (n < minStalls) begin
            $display("The unit was not busy when the read was raised after start");
            errors++;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rdValid && n < MaxWait);
        checks++;
        if (!rdValid) begin
            $display("Timeout: rdValid never rose after the read request");
            errors++;
        end else if (rdData !== expected) begin
            $display("** Error rdData %s expected %h actual %h", hi ? "HI" : "LO",
                     expected, rdData);
            errors++;
        end
    endtask

    // MTHI or MTLO with a read of the same half in the same cycle
    task automatic moveTo(input logic hi, input logic [Width-1:0] data);
        hiWr   <= hi;
        loWr   <= !hi;
        wrData <= data;
        if (hi) begin
            model[2*Width-1:Width] = data;
        end else begin
            model[Width-1:0] = data;
        end
        readHiLo(hi, 0);
    endtask

    task automatic runOp(input mduOpE code, input logic [Width-1:0] x,
                         input logic [Width-1:0] y);
        issueOp(code, x, y);
        // Divides run one step per quotient bit plus the sign fix-up
        waitIdle((code inside {OpDiv, OpDivu}) ? Width + 1 : `MUL_CYCLES);
        readHiLo(1'b1, 0);
        readHiLo(1'b0, 0);
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b0;
        start  = 1'b0;
        req    = '0;
        hiWr   = 1'b0;
        loWr   = 1'b0;
        wrData = '0;
        rdReq  = 1'b0;
        rdHi   = 1'b0;
        model  = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // ******************************
        // Products and quotients
        // ******************************
        repeat (6) begin
            runOp(($random(seed) & 1) ? OpMultu : OpMult, $random(seed), $random(seed));
        end
        runOp(OpDiv, -32'sd7, 32'd2);
        runOp(OpDiv, 32'd7, -32'sd2);
        runOp(OpDiv, -32'sd100, 32'd0);
        runOp(OpDivu, 32'd5, 32'd0);
        runOp(OpDiv, 32'h8000_0000, 32'hFFFF_FFFF);
        repeat (8) begin
            runOp(($random(seed) & 1) ? OpDivu : OpDiv, $random(seed),
                  $random(seed) & 32'h1FF);
        end

        // Accumulate from just below a LO carry
        moveTo(1'b1, 32'd0);
        moveTo(1'b0, 32'hFFFF_FFF0);
        repeat (8) begin
            pick = 2'($unsigned($random(seed)));
            runOp(accOps[pick], $random(seed), $random(seed));
        end
        repeat (4) begin
            moveTo((($random(seed) & 1) != 0), $random(seed));
        end

        // ******************************
        // Stall and dropped start
        // ******************************
        issueOp(OpMult, $random(seed), $random(seed));
        readHiLo(1'b1, 1);
        readHiLo(1'b0, 0);
        issueOp(OpDiv, $random(seed), $random(seed) & 32'hFFFF);
        start <= 1'b1;
        req   <= '{op: OpMultu, srcA: 32'hFFFF_FFFF, srcB: 32'hFFFF_FFFF};
        @(posedge clk);
        start <= 1'b0;
        readHiLo(1'b0, 1);
        readHiLo(1'b1, 0);

        errors += uut.chk.assertFails;
        $display("Read checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/mduOpPkg.sv
hdl/hiLoPkg.sv
hdl/mulDivUnit.sv
hdl/hiLoRegs.sv
hdl/moveFromHiLo.sv
hdl/mduTop.sv
test/mduTop_chk.sv
test/mduTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module mduTb -o mduSim
out=$(./obj_dir/mduSim || true)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED"
